/* dv/tb_load_unit.sv */
`timescale 1ns/1ps

module tb_load_unit;
    import lsu_pkg::*;

    localparam int DEPTH = 4;
    // the tests need about 250 cycles
    localparam int MAX_CYCLES = 2000;

    logic                       clk;
    logic                       rst_n;
    logic                       flush;
    logic                       dispatch_valid;
    logic                       dispatch_ready;
    logic [ROB_W-1:0]           dispatch_rob_id;
    load_op_e                   dispatch_op;
    logic [ARF_W-1:0]           dispatch_rd_arch;
    logic [PRF_W-1:0]           dispatch_rd_phy;
    logic                       agu_valid;
    logic [ROB_W-1:0]           agu_rob_id;
    logic [31:0]                agu_addr;
    logic [3:0]                 agu_mask;
    logic [STQ_PTR_W-1:0]       stq_tail;
    logic                       stq_deq;
    logic [DEPTH-1:0]           has_conflicting_store;
    logic [DEPTH*STQ_PTR_W-1:0] ldq_tracker;
    logic [DEPTH*32-1:0]        ldq_addr;
    logic                       dmem_valid;
    logic                       dmem_ready;
    logic [31:0]                dmem_addr;
    logic [3:0]                 dmem_rmask;
    logic                       dmem_resp;
    logic [31:0]                dmem_rdata;
    logic                       cdb_valid;
    logic [ROB_W-1:0]           cdb_rob_id;
    logic [PRF_W-1:0]           cdb_rd_phy;
    logic [ARF_W-1:0]           cdb_rd_arch;
    logic [31:0]                cdb_value;

    logic [31:0]                mem [16];
    logic [31:0]                lfsr_state;
    int                         cycle_count = 0;

    load_unit_top #(.LDQ_DEPTH(DEPTH)) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // word memory answering every accepted request one cycle later
    always @(posedge clk) begin
        dmem_resp  <= dmem_valid && dmem_ready;
        dmem_rdata <= mem[dmem_addr[5:2]];
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Verification failed");
            $fatal(1);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    // fibonacci lfsr with taps 32 22 2 1 and one step per bit
    function automatic logic [31:0] random_word();
        logic [31:0] w;
        logic        fb;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            w          = {w[30:0], fb};
        end
        return w;
    endfunction

    function automatic logic [31:0] addr_of(int widx, int off);
        return 32'(widx * 4 + off);
    endfunction

    function automatic logic [3:0] mask_for(load_op_e op, int off);
        case (op)
            LB, LBU: return 4'b0001 << off;
            LH, LHU: return 4'b0011 << off;
            default: return 4'b1111;
        endcase
    endfunction

    // byte by offset and halfword by bit 1 of the offset
    function automatic logic [31:0] expected_value(load_op_e op, logic [31:0] word, int off);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[off*8 +: 8];
        h = word[(off/2)*16 +: 16];
        case (op)
            LB:      return {{24{b[7]}}, b};
            LBU:     return {24'd0, b};
            LH:      return {{16{h[15]}}, h};
            LHU:     return {16'd0, h};
            default: return word;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s got %h expected %h", name, got, exp);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    task automatic check_result(int rob, int phy, int arch, logic [31:0] value);
        check_value("cdb_valid", 32'(cdb_valid), 32'd1);
        check_value("cdb_rob_id", 32'(cdb_rob_id), 32'(rob));
        check_value("cdb_rd_phy", 32'(cdb_rd_phy), 32'(phy));
        check_value("cdb_rd_arch", 32'(cdb_rd_arch), 32'(arch));
        check_value("cdb_value", cdb_value, value);
    endtask

    task automatic dispatch_load(int rob, load_op_e op, int arch, int phy);
        @(posedge clk);
        dispatch_valid   <= 1'b1;
        dispatch_rob_id  <= ROB_W'(rob);
        dispatch_op      <= op;
        dispatch_rd_arch <= ARF_W'(arch);
        dispatch_rd_phy  <= PRF_W'(phy);
        @(negedge clk);
        while (!dispatch_ready) @(negedge clk);
        @(posedge clk);
        dispatch_valid <= 1'b0;
    endtask

    // call right after a rising edge
    task automatic strobe_agu(int rob, logic [31:0] addr, logic [3:0] mask);
        agu_valid  <= 1'b1;
        agu_rob_id <= ROB_W'(rob);
        agu_addr   <= addr;
        agu_mask   <= mask;
    endtask

    task automatic drive_agu(int rob, logic [31:0] addr, logic [3:0] mask);
        @(posedge clk);
        strobe_agu(rob, addr, mask);
        @(posedge clk);
        agu_valid <= 1'b0;
    endtask

    task automatic wait_result(int rob, int phy, int arch, logic [31:0] value);
        @(negedge clk);
        while (!cdb_valid) @(negedge clk);
        check_result(rob, phy, arch, value);
    endtask

    // result exactly three cycles after the strobe and for one cycle only
    task automatic send_addr_expect_result(int rob, int widx, int off, load_op_e op,
                                           int arch, int phy);
        drive_agu(rob, addr_of(widx, off), mask_for(op, off));
        @(negedge clk);
        check_value("cdb_valid", 32'(cdb_valid), 32'd0);
        @(negedge clk);
        check_value("cdb_valid", 32'(cdb_valid), 32'd0);
        @(negedge clk);
        check_result(rob, phy, arch, expected_value(op, mem[widx], off));
        @(negedge clk);
        check_value("cdb_valid", 32'(cdb_valid), 32'd0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_extension();
        int       n;
        load_op_e op;
        for (int k = 0; k < 5; k++) begin
            for (int off = 0; off < 4; off++) begin
                n  = k * 4 + off;
                op = load_op_e'(3'(k));
                dispatch_load(n, op, n + 1, n + 40);
                send_addr_expect_result(n, (n * 3 + 1) % 16, off, op, n + 1, n + 40);
            end
        end
    endtask

    task automatic test_capacity();
        int rob [DEPTH];
        for (int i = 0; i < DEPTH; i++) begin
            rob[i] = 20 + i;
            dispatch_load(rob[i], LW, i + 2, i + 30);
        end
        @(negedge clk);
        check_value("dispatch_ready", 32'(dispatch_ready), 32'd0);
        check_value("dmem_valid", 32'(dmem_valid), 32'd0);
        // addresses in reverse entry order and one per cycle
        @(posedge clk);
        strobe_agu(rob[3], addr_of(7, 0), 4'hf);
        @(posedge clk);
        strobe_agu(rob[2], addr_of(6, 0), 4'hf);
        @(negedge clk);
        check_value("dmem_valid", 32'(dmem_valid), 32'd1);
        check_value("dispatch_ready", 32'(dispatch_ready), 32'd0);
        @(posedge clk);
        strobe_agu(rob[1], addr_of(5, 0), 4'hf);
        @(negedge clk);
        check_value("dispatch_ready", 32'(dispatch_ready), 32'd1);
        @(posedge clk);
        strobe_agu(rob[0], addr_of(4, 0), 4'hf);
        @(negedge clk);
        check_result(rob[3], 33, 5, mem[7]);
        @(posedge clk);
        agu_valid <= 1'b0;
        for (int i = DEPTH - 2; i >= 0; i--) begin
            @(negedge clk);
            check_result(rob[i], i + 30, i + 2, mem[4 + i]);
        end
        @(negedge clk);
        check_value("cdb_valid", 32'(cdb_valid), 32'd0);
    endtask

    task automatic test_store_order();
        @(posedge clk);
        stq_tail              <= 3'd2;
        has_conflicting_store <= 4'b0001;
        dispatch_load(1, LW, 3, 12);
        dispatch_load(2, LBU, 4, 13);
        @(negedge clk);
        check_value("ldq_tracker[0]", 32'(ldq_tracker[2:0]), 32'd2);
        check_value("ldq_tracker[1]", 32'(ldq_tracker[5:3]), 32'd2);
        drive_agu(1, addr_of(12, 0), 4'hf);
        repeat (3) begin
            @(negedge clk);
            check_value("dmem_valid", 32'(dmem_valid), 32'd0);
        end
        check_value("ldq_addr[0]", ldq_addr[31:0], addr_of(12, 0));
        // no conflict bit so it issues past the blocked load
        send_addr_expect_result(2, 13, 1, LBU, 4, 13);
        for (int d = 1; d >= 0; d--) begin
            @(posedge clk);
            stq_deq <= 1'b1;
            @(posedge clk);
            stq_deq <= 1'b0;
            @(negedge clk);
            check_value("ldq_tracker[0]", 32'(ldq_tracker[2:0]), 32'(d));
            check_value("dmem_valid", 32'(dmem_valid), 32'(d == 0));
        end
        wait_result(1, 12, 3, mem[12]);
        @(posedge clk);
        stq_tail              <= '0;
        has_conflicting_store <= '0;
    endtask

    task automatic test_backpressure();
        @(posedge clk);
        dmem_ready <= 1'b0;
        dispatch_load(5, LH, 6, 15);
        drive_agu(5, addr_of(14, 2), mask_for(LH, 2));
        repeat (5) begin
            @(negedge clk);
            check_value("dmem_valid", 32'(dmem_valid), 32'd1);
            check_value("dmem_addr", dmem_addr, addr_of(14, 0));
            check_value("dmem_rmask", 32'(dmem_rmask), 32'(mask_for(LH, 2)));
            check_value("cdb_valid", 32'(cdb_valid), 32'd0);
        end
        @(posedge clk);
        dmem_ready <= 1'b1;
        wait_result(5, 15, 6, expected_value(LH, mem[14], 2));
        repeat (3) begin
            @(negedge clk);
            check_value("cdb_valid", 32'(cdb_valid), 32'd0);
            check_value("dmem_valid", 32'(dmem_valid), 32'd0);
        end
    endtask

    task automatic test_flush();
        dispatch_load(10, LW, 7, 20);
        dispatch_load(11, LW, 8, 21);
        dispatch_load(12, LW, 9, 22);
        dispatch_load(13, LW, 10, 23);
        @(posedge clk);
        strobe_agu(10, addr_of(8, 0), 4'hf);
        @(posedge clk);
        strobe_agu(11, addr_of(9, 0), 4'hf);
        // first load goes out on this edge
        @(posedge clk);
        agu_valid        <= 1'b0;
        flush            <= 1'b1;
        dmem_ready       <= 1'b0;
        // its free slot is refilled in the flush cycle, so the queue would stay full
        dispatch_valid   <= 1'b1;
        dispatch_rob_id  <= ROB_W'(15);
        dispatch_op      <= LW;
        dispatch_rd_arch <= ARF_W'(11);
        dispatch_rd_phy  <= PRF_W'(25);
        @(negedge clk);
        check_value("dmem_valid", 32'(dmem_valid), 32'd0);
        check_value("dmem_resp", 32'(dmem_resp), 32'd1);
        @(posedge clk);
        flush          <= 1'b0;
        dmem_ready     <= 1'b1;
        dispatch_valid <= 1'b0;
        repeat (5) begin
            @(negedge clk);
            check_value("cdb_valid", 32'(cdb_valid), 32'd0);
            check_value("dmem_valid", 32'(dmem_valid), 32'd0);
            check_value("dispatch_ready", 32'(dispatch_ready), 32'd1);
        end
        dispatch_load(14, LH, 10, 24);
        send_addr_expect_result(14, 11, 2, LH, 10, 24);
    endtask

    initial begin
        rst_n                 = 1'b0;
        flush                 = 1'b0;
        dispatch_valid        = 1'b0;
        dispatch_rob_id       = '0;
        dispatch_op           = LW;
        dispatch_rd_arch      = '0;
        dispatch_rd_phy       = '0;
        agu_valid             = 1'b0;
        agu_rob_id            = '0;
        agu_addr              = '0;
        agu_mask              = '0;
        stq_tail              = '0;
        stq_deq               = 1'b0;
        has_conflicting_store = '0;
        dmem_ready            = 1'b1;
        dmem_resp             = 1'b0;
        dmem_rdata            = '0;
        lfsr_state            = 32'hb7cb;
        for (int i = 0; i < 16; i++) begin
            mem[i] = random_word();
        end
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("dmem_valid", 32'(dmem_valid), 32'd0);
        check_value("cdb_valid", 32'(cdb_valid), 32'd0);
        check_value("dispatch_ready", 32'(dispatch_ready), 32'd1);

        test_extension();
        test_capacity();
        test_store_order();
        test_backpressure();
        test_flush();

        $display("Verification passed");
        $finish;
    end

endmodule

/* load_unit_top.f */
rtl/lsu_pkg.sv
rtl/ldq_if.sv
rtl/ldq_entries.sv
rtl/load_access.sv
rtl/load_align_wb.sv
rtl/load_unit_top.sv
dv/tb_load_unit.sv

/* rtl/ldq_entries.sv */
`timescale 1ns/1ps

module ldq_entries #(
    parameter int LDQ_DEPTH = 4
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    flush,

    input  logic                                    dispatch_valid,
    output logic                                    dispatch_ready,
    input  logic [lsu_pkg::ROB_W-1:0]               dispatch_rob_id,
    input  lsu_pkg::load_op_e                       dispatch_op,
    input  logic [lsu_pkg::ARF_W-1:0]               dispatch_rd_arch,
    input  logic [lsu_pkg::PRF_W-1:0]               dispatch_rd_phy,

    input  logic                                    agu_valid,
    input  logic [lsu_pkg::ROB_W-1:0]               agu_rob_id,
    input  logic [31:0]                             agu_addr,
    input  logic [3:0]                              agu_mask,

    input  logic [lsu_pkg::STQ_PTR_W-1:0]           stq_tail,
    input  logic                                    stq_deq,
    input  logic [LDQ_DEPTH-1:0]                    has_conflicting_store,
    output logic [LDQ_DEPTH*lsu_pkg::STQ_PTR_W-1:0] ldq_tracker,
    output logic [LDQ_DEPTH*32-1:0]                 ldq_addr,

    ldq_issue_if.queue                              iss
);
    import lsu_pkg::*;

    localparam int IDX_W = (LDQ_DEPTH > 1) ? $clog2(LDQ_DEPTH) : 1;

    ldq_entry_t         q     [LDQ_DEPTH];
    ldq_entry_t         q_nxt [LDQ_DEPTH];

    logic               push_en;
    logic [IDX_W-1:0]   push_idx;
    logic               issue_en;
    logic [IDX_W-1:0]   issue_idx;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < LDQ_DEPTH; i++) begin
                q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < LDQ_DEPTH; i++) begin
                q[i] <= q_nxt[i];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < LDQ_DEPTH; i++) begin
            q_nxt[i] = q[i];
        end

        // older store left the store queue
        if (stq_deq) begin
            for (int i = 0; i < LDQ_DEPTH; i++) begin
                if (q[i].track_stq_ptr != '0) begin
                    q_nxt[i].track_stq_ptr = q[i].track_stq_ptr - 1'b1;
                end
            end
        end

        // address arrives by rob id
        if (agu_valid) begin
            for (int i = 0; i < LDQ_DEPTH; i++) begin
                if (q[i].valid && q[i].rob_id == agu_rob_id) begin
                    q_nxt[i].addr_valid = 1'b1;
                    q_nxt[i].addr       = agu_addr;
                    q_nxt[i].mask       = agu_mask;
                end
            end
        end

        if (push_en) begin
            q_nxt[push_idx].valid         = 1'b1;
            q_nxt[push_idx].addr_valid    = 1'b0;
            q_nxt[push_idx].track_stq_ptr = stq_deq ? stq_tail - 1'b1 : stq_tail;
            q_nxt[push_idx].rob_id        = dispatch_rob_id;
            q_nxt[push_idx].op            = dispatch_op;
            q_nxt[push_idx].rd_arch       = dispatch_rd_arch;
            q_nxt[push_idx].rd_phy        = dispatch_rd_phy;
        end

        // slot is free once the request transfers
        if (issue_en && iss.ready) begin
            q_nxt[issue_idx].valid = 1'b0;
        end

        if (flush) begin
            for (int i = 0; i < LDQ_DEPTH; i++) begin
                q_nxt[i].valid = 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // allocation
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        dispatch_ready = 1'b0;
        push_idx       = '0;
        for (int i = LDQ_DEPTH - 1; i >= 0; i--) begin
            if (!q[i].valid) begin
                dispatch_ready = 1'b1;
                push_idx       = IDX_W'(i);
            end
        end
    end

    assign push_en = dispatch_valid && dispatch_ready;

    //////////////////////////////////////////////////////////////////////
    // issue select
    //////////////////////////////////////////////////////////////////////

    // lowest index wins, no older conflicting store pending
    always_comb begin
        issue_en  = 1'b0;
        issue_idx = '0;
        for (int i = LDQ_DEPTH - 1; i >= 0; i--) begin
            if (q[i].valid && q[i].addr_valid &&
                (q[i].track_stq_ptr == '0 || !has_conflicting_store[i])) begin
                issue_en  = 1'b1;
                issue_idx = IDX_W'(i);
            end
        end
    end

    assign iss.valid   = issue_en;
    assign iss.rob_id  = q[issue_idx].rob_id;
    assign iss.rd_phy  = q[issue_idx].rd_phy;
    assign iss.rd_arch = q[issue_idx].rd_arch;
    assign iss.op      = q[issue_idx].op;
    assign iss.addr    = q[issue_idx].addr;
    assign iss.mask    = q[issue_idx].mask;

    // readback for the store queue
    for (genvar i = 0; i < LDQ_DEPTH; i++) begin : g_readback
        assign ldq_tracker[i*STQ_PTR_W +: STQ_PTR_W] = q[i].track_stq_ptr;
        assign ldq_addr[i*32 +: 32]                  = q[i].addr;
    end

endmodule

/* rtl/ldq_if.sv */
`timescale 1ns/1ps

// queue to access stage, one load request
interface ldq_issue_if;
    import lsu_pkg::*;

    logic               valid;
    logic               ready;
    logic [ROB_W-1:0]   rob_id;
    logic [PRF_W-1:0]   rd_phy;
    logic [ARF_W-1:0]   rd_arch;
    load_op_e           op;
    logic [31:0]        addr;
    logic [3:0]         mask;

    modport queue (output valid, rob_id, rd_phy, rd_arch, op, addr, mask, input ready);
    modport mem   (input valid, rob_id, rd_phy, rd_arch, op, addr, mask, output ready);
endinterface

// access stage to align stage, response plus tag of the load in flight
interface load_tag_if;
    import lsu_pkg::*;

    logic               resp;
    logic [31:0]        rdata;
    logic [ROB_W-1:0]   rob_id;
    logic [PRF_W-1:0]   rd_phy;
    logic [ARF_W-1:0]   rd_arch;
    load_op_e           op;
    logic [1:0]         byte_off;

    modport src  (output resp, rdata, rob_id, rd_phy, rd_arch, op, byte_off);
    modport sink (input resp, rdata, rob_id, rd_phy, rd_arch, op, byte_off);
endinterface

/* rtl/load_access.sv */
`timescale 1ns/1ps

module load_access (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            flush,

    ldq_issue_if.mem        iss,
    load_tag_if.src         tag,

    output logic            dmem_valid,
    input  logic            dmem_ready,
    output logic [31:0]     dmem_addr,
    output logic [3:0]      dmem_rmask,
    input  logic            dmem_resp,
    input  logic [31:0]     dmem_rdata
);
    logic fire;
    logic tag_valid;

    // no new request while the backend flushes
    assign dmem_valid = iss.valid && !flush;
    assign dmem_addr  = {iss.addr[31:2], 2'b00};
    assign dmem_rmask = iss.mask;
    assign iss.ready  = dmem_ready;

    assign fire = dmem_valid && dmem_ready;

    // tag in flight, cleared when its response returns
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tag_valid <= 1'b0;
        end else if (flush) begin
            tag_valid <= 1'b0;
        end else if (fire) begin
            tag_valid <= 1'b1;
        end else if (dmem_resp) begin
            tag_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            tag.rob_id   <= iss.rob_id;
            tag.rd_phy   <= iss.rd_phy;
            tag.rd_arch  <= iss.rd_arch;
            tag.op       <= iss.op;
            tag.byte_off <= iss.addr[1:0];
        end
    end

    // response only counts for a live tag
    assign tag.resp  = dmem_resp && tag_valid;
    assign tag.rdata = dmem_rdata;

endmodule

/* rtl/load_align_wb.sv */
`timescale 1ns/1ps

module load_align_wb (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        flush,

    load_tag_if.sink                    tag,

    output logic                        cdb_valid,
    output logic [lsu_pkg::ROB_W-1:0]   cdb_rob_id,
    output logic [lsu_pkg::PRF_W-1:0]   cdb_rd_phy,
    output logic [lsu_pkg::ARF_W-1:0]   cdb_rd_arch,
    output logic [31:0]                 cdb_value
);
    import lsu_pkg::*;

    mem_word_u      word;
    logic [7:0]     byte_sel;
    logic [15:0]    half_sel;
    logic [31:0]    value;

    assign word     = tag.rdata;
    assign byte_sel = word.bytes[tag.byte_off];
    // halfword by bit 1 only
    assign half_sel = word.halves[tag.byte_off[1]];

    //////////////////////////////////////////////////////////////////////
    // extension
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (tag.op)
            LB:      value = {{24{byte_sel[7]}}, byte_sel};
            LBU:     value = {24'd0, byte_sel};
            LH:      value = {{16{half_sel[15]}}, half_sel};
            LHU:     value = {16'd0, half_sel};
            LW:      value = word;
            default: value = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // cdb result register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cdb_valid <= 1'b0;
        end else begin
            // one cycle per response
            cdb_valid <= tag.resp && !flush;
        end
    end

    always_ff @(posedge clk) begin
        if (tag.resp) begin
            cdb_rob_id  <= tag.rob_id;
            cdb_rd_phy  <= tag.rd_phy;
            cdb_rd_arch <= tag.rd_arch;
            cdb_value   <= value;
        end
    end

endmodule

/* rtl/load_unit_top.sv */
`timescale 1ns/1ps

module load_unit_top #(
    parameter int LDQ_DEPTH = 4
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    flush,

    // dispatch
    input  logic                                    dispatch_valid,
    output logic                                    dispatch_ready,
    input  logic [lsu_pkg::ROB_W-1:0]               dispatch_rob_id,
    input  lsu_pkg::load_op_e                       dispatch_op,
    input  logic [lsu_pkg::ARF_W-1:0]               dispatch_rd_arch,
    input  logic [lsu_pkg::PRF_W-1:0]               dispatch_rd_phy,

    // address generation
    input  logic                                    agu_valid,
    input  logic [lsu_pkg::ROB_W-1:0]               agu_rob_id,
    input  logic [31:0]                             agu_addr,
    input  logic [3:0]                              agu_mask,

    // store queue side
    input  logic [lsu_pkg::STQ_PTR_W-1:0]           stq_tail,
    input  logic                                    stq_deq,
    input  logic [LDQ_DEPTH-1:0]                    has_conflicting_store,
    output logic [LDQ_DEPTH*lsu_pkg::STQ_PTR_W-1:0] ldq_tracker,
    output logic [LDQ_DEPTH*32-1:0]                 ldq_addr,

    // data memory
    output logic                                    dmem_valid,
    input  logic                                    dmem_ready,
    output logic [31:0]                             dmem_addr,
    output logic [3:0]                              dmem_rmask,
    input  logic                                    dmem_resp,
    input  logic [31:0]                             dmem_rdata,

    // common data bus
    output logic                                    cdb_valid,
    output logic [lsu_pkg::ROB_W-1:0]               cdb_rob_id,
    output logic [lsu_pkg::PRF_W-1:0]               cdb_rd_phy,
    output logic [lsu_pkg::ARF_W-1:0]               cdb_rd_arch,
    output logic [31:0]                             cdb_value
);
    ldq_issue_if iss_if ();
    load_tag_if  tag_if ();

    ldq_entries #(
        .LDQ_DEPTH (LDQ_DEPTH)
    ) u_entries (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .flush                 (flush),
        .dispatch_valid        (dispatch_valid),
        .dispatch_ready        (dispatch_ready),
        .dispatch_rob_id       (dispatch_rob_id),
        .dispatch_op           (dispatch_op),
        .dispatch_rd_arch      (dispatch_rd_arch),
        .dispatch_rd_phy       (dispatch_rd_phy),
        .agu_valid             (agu_valid),
        .agu_rob_id            (agu_rob_id),
        .agu_addr              (agu_addr),
        .agu_mask              (agu_mask),
        .stq_tail              (stq_tail),
        .stq_deq               (stq_deq),
        .has_conflicting_store (has_conflicting_store),
        .ldq_tracker           (ldq_tracker),
        .ldq_addr              (ldq_addr),
        .iss                   (iss_if.queue)
    );

    load_access u_access (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .iss        (iss_if.mem),
        .tag        (tag_if.src),
        .dmem_valid (dmem_valid),
        .dmem_ready (dmem_ready),
        .dmem_addr  (dmem_addr),
        .dmem_rmask (dmem_rmask),
        .dmem_resp  (dmem_resp),
        .dmem_rdata (dmem_rdata)
    );

    load_align_wb u_align_wb (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .tag         (tag_if.sink),
        .cdb_valid   (cdb_valid),
        .cdb_rob_id  (cdb_rob_id),
        .cdb_rd_phy  (cdb_rd_phy),
        .cdb_rd_arch (cdb_rd_arch),
        .cdb_value   (cdb_value)
    );

endmodule

/* rtl/lsu_pkg.sv */
package lsu_pkg;

    //////////////////////////////////////////////////////////////////////
    // index widths
    //////////////////////////////////////////////////////////////////////

    // reorder buffer slot
    localparam int ROB_W = 5;
    // physical and architectural register files
    localparam int PRF_W = 6;
    localparam int ARF_W = 5;
    // store queue of 8, tail pointer and per-load tracker
    localparam int STQ_PTR_W = 3;

    //////////////////////////////////////////////////////////////////////
    // load opcodes
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        LB  = 3'd0,
        LBU = 3'd1,
        LH  = 3'd2,
        LHU = 3'd3,
        LW  = 3'd4
    } load_op_e;

    // one load queue slot
    typedef struct packed {
        logic                   valid;
        logic                   addr_valid;
        logic [STQ_PTR_W-1:0]   track_stq_ptr;
        logic [ROB_W-1:0]       rob_id;
        load_op_e               op;
        logic [ARF_W-1:0]       rd_arch;
        logic [PRF_W-1:0]       rd_phy;
        logic [31:0]            addr;
        logic [3:0]             mask;
    } ldq_entry_t;

    // returned read word, seen as bytes or as halfwords
    typedef union packed {
        logic [3:0][7:0]        bytes;
        logic [1:0][15:0]       halves;
    } mem_word_u;

endpackage

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f load_unit_top.f --top-module tb_load_unit -o sim_load_unit

output=$(./obj_dir/sim_load_unit 2>&1) || true
echo "$output"

if echo "$output" | grep -qx "Verification passed"; then
    exit 0
fi
exit 1
